// ==== hw/dm_split_pkg.sv ====
// Assumes byte addresses and lengths are multiples of 8 and lengths are nonzero; no tkeep
package dm_split_pkg;

    // ============================================================
    // Bus and field widths
    // ============================================================

    // Data bus width and the number of bytes carried by one beat
    localparam int BUS_W = 64;
    localparam int BUS_BYTES = 8;

    // Shift that turns a byte count into a beat count
    localparam int BEAT_SHIFT = $clog2(BUS_BYTES);

    // Header field widths, which together fill exactly one beat
    localparam int LEN_W = 13;
    localparam int ADDR_W = 40;
    localparam int TAG_W = 8;

    // Width of a beat count derived from a byte length
    localparam int BEATS_W = LEN_W - BEAT_SHIFT;

    // Largest chunk, which is also the alignment boundary for splits
    localparam int MAX_CHUNK_BYTES = 64;
    localparam int CHUNK_OFF_W = $clog2(MAX_CHUNK_BYTES);
    localparam logic [LEN_W-1:0] MAX_CHUNK_LEN = LEN_W'(MAX_CHUNK_BYTES);

    // Write payload buffering, kept a power of two so the pointers wrap on their own
    localparam int PAYLOAD_DEPTH = 16;
    localparam int PTR_W = $clog2(PAYLOAD_DEPTH);

    // ============================================================
    // Stream and header types
    // ============================================================

    typedef logic [BUS_W-1:0] bus_word_t;

    // The kind field sits in the top two bits of every header layout
    typedef enum logic [1:0] {
        KIND_READ  = 2'd0,
        KIND_WRITE = 2'd1,
        KIND_MSG   = 2'd2,
        KIND_RSVD  = 2'd3
    } req_kind_e;

    // Memory read or write request, with the byte length and byte address
    typedef struct packed {
        req_kind_e         kind;
        logic              final_chunk;
        logic [TAG_W-1:0]  tag;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
    } dm_req_hdr_t;

    // Message header, carried through untouched
    typedef struct packed {
        req_kind_e   kind;
        logic [7:0]  msg_code;
        logic [53:0] raw;
    } dm_msg_hdr_t;

    // One header beat, read through whichever layout its kind selects
    typedef union packed {
        dm_req_hdr_t req;
        dm_msg_hdr_t msg;
    } hdr_word_u;

endpackage

// ==== hw/hdr_data_separator.sv ====
// First beat of every packet is taken as a header; only write headers may be followed by data
module hdr_data_separator (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_in_valid,
    input  dm_split_pkg::bus_word_t i_in_data,
    input  logic                    i_in_last,
    output logic                    o_in_ready,
    output logic                    o_hdr_valid,
    input  logic                    i_hdr_ready,
    output dm_split_pkg::hdr_word_u o_hdr_data,
    output logic                    o_pay_valid,
    input  logic                    i_pay_ready,
    output dm_split_pkg::bus_word_t o_pay_data
);

    // High while the next input beat opens a new packet
    logic sop_q;
    // Held low through reset and the first cycle after it, so no input is taken early
    logic run_q;
    logic hdr_valid_q;
    dm_split_pkg::hdr_word_u hdr_data_q;
    logic hdr_free;
    logic in_fire;

    // The header slot can take a beat when empty or when its content leaves now
    assign hdr_free = !hdr_valid_q || i_hdr_ready;

    // Ready follows the stage that the current beat is headed for
    assign o_in_ready = run_q && (sop_q ? hdr_free : i_pay_ready);
    assign in_fire = i_in_valid && o_in_ready;

    // Payload beats pass straight on to the FIFO without a register
    assign o_pay_valid = i_in_valid && run_q && !sop_q;
    assign o_pay_data = i_in_data;

    assign o_hdr_valid = hdr_valid_q;
    assign o_hdr_data = hdr_data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            sop_q <= 1'b1;
            hdr_valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            // The beat after a last beat starts the next packet
            if (in_fire) begin
                sop_q <= i_in_last;
            end
            if (in_fire && sop_q) begin
                hdr_valid_q <= 1'b1;
            end else if (i_hdr_ready) begin
                hdr_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire && sop_q) begin
            hdr_data_q <= i_in_data;
        end
    end

endmodule

// ==== hw/payload_fifo.sv ====
// Synchronous FIFO with a combinational read port; depth must be a power of two
module payload_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_wr_valid,
    input  dm_split_pkg::bus_word_t i_wr_data,
    output logic                    o_wr_ready,
    output logic                    o_rd_valid,
    input  logic                    i_rd_ready,
    output dm_split_pkg::bus_word_t o_rd_data
);

    dm_split_pkg::bus_word_t mem [dm_split_pkg::PAYLOAD_DEPTH];
    logic [dm_split_pkg::PTR_W-1:0] wr_ptr_q;
    logic [dm_split_pkg::PTR_W-1:0] rd_ptr_q;
    // One bit wider than the pointers so a full FIFO can be told from an empty one
    logic [dm_split_pkg::PTR_W:0] count_q;
    logic wr_fire;
    logic rd_fire;

    assign o_wr_ready = (count_q != dm_split_pkg::PAYLOAD_DEPTH);
    assign o_rd_valid = (count_q != '0);
    assign o_rd_data = mem[rd_ptr_q];

    assign wr_fire = i_wr_valid && o_wr_ready;
    assign rd_fire = o_rd_valid && i_rd_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // A push and a pop in the same cycle leave the count alone
            if (wr_fire && !rd_fire) begin
                count_q <= count_q + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q] <= i_wr_data;
        end
    end

endmodule

// ==== hw/req_chunker.sv ====
// Splits reads and writes at 64-byte boundaries; the incoming final-chunk flag is ignored
module req_chunker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_hdr_valid,
    output logic                    o_hdr_ready,
    input  dm_split_pkg::hdr_word_u i_hdr_data,
    output logic                    o_chunk_valid,
    input  logic                    i_chunk_ready,
    output dm_split_pkg::hdr_word_u o_chunk_data
);

    // ============================================================
    // Request state
    // ============================================================

    // High while a request still has chunks to emit
    logic busy_q;
    // Original header, kept for the kind and tag and for message pass-through
    dm_split_pkg::hdr_word_u held_q;
    // Start address of the next chunk and the bytes not yet covered
    logic [dm_split_pkg::ADDR_W-1:0] cur_addr_q;
    logic [dm_split_pkg::LEN_W-1:0] rem_len_q;

    logic is_mem;
    logic [dm_split_pkg::LEN_W-1:0] addr_off;
    logic [dm_split_pkg::LEN_W-1:0] to_boundary;
    logic [dm_split_pkg::LEN_W-1:0] chunk_len;
    logic chunk_final;
    logic hdr_fire;
    logic chunk_fire;

    // ============================================================
    // Chunk sizing
    // ============================================================

    // Only reads and writes are split, every other kind is one header
    assign is_mem = (held_q.req.kind == dm_split_pkg::KIND_READ) ||
                    (held_q.req.kind == dm_split_pkg::KIND_WRITE);

    // Bytes from the current address up to the next aligned block edge
    assign addr_off = {{(dm_split_pkg::LEN_W - dm_split_pkg::CHUNK_OFF_W){1'b0}},
                       cur_addr_q[dm_split_pkg::CHUNK_OFF_W-1:0]};
    assign to_boundary = dm_split_pkg::MAX_CHUNK_LEN - addr_off;

    // The chunk stops at the block edge or at the end of the request
    assign chunk_len = (rem_len_q < to_boundary) ? rem_len_q : to_boundary;

    // Nothing is left once this chunk covers all remaining bytes
    assign chunk_final = !is_mem || (rem_len_q == chunk_len);

    always_comb begin
        o_chunk_data = held_q;
        if (is_mem) begin
            o_chunk_data.req.final_chunk = chunk_final;
            o_chunk_data.req.len = chunk_len;
            o_chunk_data.req.addr = cur_addr_q;
        end
    end

    // ============================================================
    // Handshakes
    // ============================================================

    assign o_chunk_valid = busy_q;
    assign chunk_fire = busy_q && i_chunk_ready;

    // A new header is taken only while idle or as the final chunk leaves
    assign o_hdr_ready = !busy_q || (i_chunk_ready && chunk_final);
    assign hdr_fire = i_hdr_valid && o_hdr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (hdr_fire) begin
            busy_q <= 1'b1;
        end else if (chunk_fire && chunk_final) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            held_q <= i_hdr_data;
            cur_addr_q <= i_hdr_data.req.addr;
            rem_len_q <= i_hdr_data.req.len;
        end else if (chunk_fire) begin
            // Step past the chunk that has just been sent
            cur_addr_q <= cur_addr_q +
                          {{(dm_split_pkg::ADDR_W - dm_split_pkg::LEN_W){1'b0}}, chunk_len};
            rem_len_q <= rem_len_q - chunk_len;
        end
    end

endmodule

// ==== hw/chunk_merge.sv ====
// Write chunk lengths must be whole beats and the FIFO must hold the data in header order
module chunk_merge (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_chunk_valid,
    output logic                    o_chunk_ready,
    input  dm_split_pkg::hdr_word_u i_chunk_data,
    input  logic                    i_pay_valid,
    output logic                    o_pay_ready,
    input  dm_split_pkg::bus_word_t i_pay_data,
    output logic                    o_out_valid,
    input  logic                    i_out_ready,
    output dm_split_pkg::bus_word_t o_out_data,
    output logic                    o_out_last
);

    // Output register
    logic out_valid_q;
    dm_split_pkg::bus_word_t out_data_q;
    logic out_last_q;
    // High while data beats of the current write chunk are still owed
    logic in_data_q;
    logic [dm_split_pkg::BEATS_W-1:0] beats_left_q;

    logic out_free;
    logic [dm_split_pkg::BEATS_W-1:0] chunk_beats;
    logic chunk_fire;
    logic pay_fire;

    // The register can load when empty or when its beat leaves this cycle
    assign out_free = !out_valid_q || i_out_ready;

    // Only writes carry data, one beat per eight bytes of length
    assign chunk_beats = (i_chunk_data.req.kind == dm_split_pkg::KIND_WRITE) ?
                         i_chunk_data.req.len[dm_split_pkg::LEN_W-1:dm_split_pkg::BEAT_SHIFT] :
                         '0;

    // Headers and data take turns, so exactly one side is offered the register
    assign o_chunk_ready = out_free && !in_data_q;
    assign o_pay_ready = out_free && in_data_q;
    assign chunk_fire = i_chunk_valid && o_chunk_ready;
    assign pay_fire = i_pay_valid && o_pay_ready;

    assign o_out_valid = out_valid_q;
    assign o_out_data = out_data_q;
    assign o_out_last = out_last_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            in_data_q <= 1'b0;
            beats_left_q <= '0;
        end else if (chunk_fire) begin
            out_valid_q <= 1'b1;
            in_data_q <= (chunk_beats != '0);
            beats_left_q <= chunk_beats;
        end else if (pay_fire) begin
            out_valid_q <= 1'b1;
            beats_left_q <= beats_left_q - 1'b1;
            // Return to header mode after the chunk's final beat
            if (beats_left_q == 1) begin
                in_data_q <= 1'b0;
            end
        end else if (i_out_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (chunk_fire) begin
            out_data_q <= i_chunk_data;
            // A header ends its packet only when no data follows it
            out_last_q <= (chunk_beats == '0);
        end else if (pay_fire) begin
            out_data_q <= i_pay_data;
            out_last_q <= (beats_left_q == 1);
        end
    end

endmodule

// ==== hw/dm_req_splitter.sv ====
// Request splitter top; input packets must be well formed, output is at least 3 cycles behind
module dm_req_splitter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_in_valid,
    output logic                    o_in_ready,
    input  dm_split_pkg::bus_word_t i_in_data,
    input  logic                    i_in_last,
    output logic                    o_out_valid,
    input  logic                    i_out_ready,
    output dm_split_pkg::bus_word_t o_out_data,
    output logic                    o_out_last
);

    // Header link from the separator to the chunker
    logic hdr_valid;
    logic hdr_ready;
    dm_split_pkg::hdr_word_u hdr_data;

    // Write data from the separator into the FIFO
    logic sep_pay_valid;
    logic sep_pay_ready;
    dm_split_pkg::bus_word_t sep_pay_data;

    // Chunk headers from the chunker to the merge
    logic chunk_valid;
    logic chunk_ready;
    dm_split_pkg::hdr_word_u chunk_data;

    // Buffered write data from the FIFO to the merge
    logic fifo_pay_valid;
    logic fifo_pay_ready;
    dm_split_pkg::bus_word_t fifo_pay_data;

    hdr_data_separator u_separator (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .i_in_last   (i_in_last),
        .o_in_ready  (o_in_ready),
        .o_hdr_valid (hdr_valid),
        .i_hdr_ready (hdr_ready),
        .o_hdr_data  (hdr_data),
        .o_pay_valid (sep_pay_valid),
        .i_pay_ready (sep_pay_ready),
        .o_pay_data  (sep_pay_data)
    );

    payload_fifo u_payload_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr_valid (sep_pay_valid),
        .i_wr_data  (sep_pay_data),
        .o_wr_ready (sep_pay_ready),
        .o_rd_valid (fifo_pay_valid),
        .i_rd_ready (fifo_pay_ready),
        .o_rd_data  (fifo_pay_data)
    );

    req_chunker u_chunker (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_hdr_valid   (hdr_valid),
        .o_hdr_ready   (hdr_ready),
        .i_hdr_data    (hdr_data),
        .o_chunk_valid (chunk_valid),
        .i_chunk_ready (chunk_ready),
        .o_chunk_data  (chunk_data)
    );

    chunk_merge u_merge (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_chunk_valid (chunk_valid),
        .o_chunk_ready (chunk_ready),
        .i_chunk_data  (chunk_data),
        .i_pay_valid   (fifo_pay_valid),
        .o_pay_ready   (fifo_pay_ready),
        .i_pay_data    (fifo_pay_data),
        .o_out_valid   (o_out_valid),
        .i_out_ready   (i_out_ready),
        .o_out_data    (o_out_data),
        .o_out_last    (o_out_last)
    );

endmodule

// ==== verif/dm_req_splitter_checker.sv ====
// Output-side assertions; header detection assumes the first beat after reset opens a packet
module dm_req_splitter_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    o_out_valid,
    input logic                    i_out_ready,
    input dm_split_pkg::bus_word_t o_out_data,
    input logic                    o_out_last
);

    // High while the next output beat is a header
    logic out_sop_q;
    dm_split_pkg::hdr_word_u hdr_view;

    assign hdr_view = o_out_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_sop_q <= 1'b1;
        end else if (o_out_valid && i_out_ready) begin
            out_sop_q <= o_out_last;
        end
    end

    // A stalled beat keeps its valid, data and last flag
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data) && $stable(o_out_last))
        else $error("output beat changed while stalled");

    reset_idle: assert property (@(posedge clk) !rst_n |=> !o_out_valid)
        else $error("o_out_valid high after a reset cycle");

    // Memory request headers never exceed one aligned block
    chunk_size: assert property (@(posedge clk) disable iff (!rst_n)
        o_out_valid && out_sop_q &&
        (hdr_view.req.kind == dm_split_pkg::KIND_READ ||
         hdr_view.req.kind == dm_split_pkg::KIND_WRITE)
        |-> hdr_view.req.len <= dm_split_pkg::MAX_CHUNK_LEN)
        else $error("chunk length %0d above the limit", hdr_view.req.len);

endmodule

bind dm_req_splitter dm_req_splitter_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_out_data  (o_out_data),
    .o_out_last  (o_out_last)
);

// ==== verif/dm_req_splitter_tb.sv ====
// Drives the splitter from a request table under random output stalls; stops at the first mismatch
module dm_req_splitter_tb;

    // One table row per request, with the chunk count that the split must produce
    typedef struct packed {
        dm_split_pkg::req_kind_e kind;
        logic [7:0]              tag;
        logic [39:0]             addr;
        logic [12:0]             len;
        logic [7:0]              code;
        int                      chunks;
    } stim_t;

    localparam int N_REQ = 10;

    logic clk;
    logic rst_n;
    logic i_in_valid;
    logic o_in_ready;
    dm_split_pkg::bus_word_t i_in_data;
    logic i_in_last;
    logic o_out_valid;
    logic i_out_ready;
    dm_split_pkg::bus_word_t o_out_data;
    logic o_out_last;

    stim_t stim [N_REQ];
    // Expected output stream, one entry per beat, with a flag telling headers from data
    dm_split_pkg::bus_word_t exp_word [$];
    logic exp_last [$];
    logic exp_hdr [$];
    int n_expected;
    int n_seen;
    int n_input;
    logic model_ready;
    logic [31:0] rng_state;

    dm_req_splitter DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_in_data   (i_in_data),
        .i_in_last   (i_in_last),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready),
        .o_out_data  (o_out_data),
        .o_out_last  (o_out_last)
    );

    // ============================================================
    // Helpers
    // ============================================================

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Rows cover behaviors 1 to 4 first, then a mixed tail for the back-to-back run
    task automatic load_table();
        stim[0] = '{dm_split_pkg::KIND_READ,  8'h11, 40'h100, 13'd32,   8'h00, 1};
        stim[1] = '{dm_split_pkg::KIND_READ,  8'h22, 40'h028, 13'd200,  8'h00, 4};
        stim[2] = '{dm_split_pkg::KIND_WRITE, 8'h33, 40'h030, 13'd80,   8'h00, 2};
        stim[3] = '{dm_split_pkg::KIND_MSG,   8'h3c, 40'h0ab, 13'd0,    8'h5a, 1};
        stim[4] = '{dm_split_pkg::KIND_WRITE, 8'h44, 40'h1f8, 13'd136,  8'h00, 3};
        stim[5] = '{dm_split_pkg::KIND_READ,  8'h55, 40'h040, 13'd64,   8'h00, 1};
        stim[6] = '{dm_split_pkg::KIND_MSG,   8'h66, 40'h123, 13'd0,    8'ha5, 1};
        stim[7] = '{dm_split_pkg::KIND_WRITE, 8'h77, 40'h008, 13'd8,    8'h00, 1};
        stim[8] = '{dm_split_pkg::KIND_READ,  8'h88, 40'h3c0, 13'd1024, 8'h00, 16};
        stim[9] = '{dm_split_pkg::KIND_WRITE, 8'h99, 40'h7f0, 13'd48,   8'h00, 2};
    endtask

    // Messages put the tag and address into the raw bits so that every bit is exercised
    function automatic dm_split_pkg::hdr_word_u make_header(input stim_t s);
        dm_split_pkg::hdr_word_u h;
        h = '0;
        if (s.kind == dm_split_pkg::KIND_MSG) begin
            h.msg.kind = s.kind;
            h.msg.msg_code = s.code;
            h.msg.raw = {6'h00, s.tag, s.addr};
        end else begin
            h.req.kind = s.kind;
            h.req.tag = s.tag;
            h.req.len = s.len;
            h.req.addr = s.addr;
        end
        return h;
    endfunction

    task automatic push_expected(input dm_split_pkg::bus_word_t w, input logic l, input logic h);
        exp_word.push_back(w);
        exp_last.push_back(l);
        exp_hdr.push_back(h);
    endtask

    // ============================================================
    // Reference model
    // ============================================================

    // Chunks end at the next 64-byte edge or at the end of the request
    task automatic build_expected();
        stim_t s;
        dm_split_pkg::hdr_word_u h;
        dm_split_pkg::hdr_word_u c;
        longint a;
        int rem;
        int room;
        int cl;
        int beat;
        int chunks;
        for (int r = 0; r < N_REQ; r++) begin
            s = stim[r];
            h = make_header(s);
            n_input += 1;
            chunks = 0;
            if (s.kind != dm_split_pkg::KIND_READ && s.kind != dm_split_pkg::KIND_WRITE) begin
                push_expected(h, 1'b1, 1'b1);
                chunks = 1;
            end else begin
                a = longint'(s.addr);
                rem = int'(s.len);
                beat = 0;
                while (rem > 0) begin
                    room = dm_split_pkg::MAX_CHUNK_BYTES -
                           int'(a % dm_split_pkg::MAX_CHUNK_BYTES);
                    cl = (rem < room) ? rem : room;
                    c = h;
                    c.req.final_chunk = (cl == rem);
                    c.req.len = 13'(cl);
                    c.req.addr = 40'(a);
                    push_expected(c, s.kind != dm_split_pkg::KIND_WRITE, 1'b1);
                    if (s.kind == dm_split_pkg::KIND_WRITE) begin
                        for (int i = 0; i < cl / 8; i++) begin
                            push_expected({s.tag, 56'(beat)}, i == cl / 8 - 1, 1'b0);
                            beat++;
                        end
                        n_input += cl / 8;
                    end
                    a = a + cl;
                    rem = rem - cl;
                    chunks++;
                end
            end
            if (chunks != s.chunks) begin
                $display("Request %0d splits into %0d chunks, the table expects %0d",
                         r, chunks, s.chunks);
                stop_run();
            end
        end
        n_expected = exp_word.size();
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic compare_hdr(input dm_split_pkg::hdr_word_u got,
                               input dm_split_pkg::hdr_word_u exp,
                               input logic got_last, input logic exp_last_bit);
        if (got !== exp) begin
            $display("[FAIL] t=%0t o_out_data header: got %h, expected %h", $time, got, exp);
            stop_run();
        end else if (got_last !== exp_last_bit) begin
            $display("[FAIL] t=%0t o_out_last on header: got %b, expected %b",
                     $time, got_last, exp_last_bit);
            stop_run();
        end
    endtask

    task automatic compare_beat(input dm_split_pkg::bus_word_t got,
                                input dm_split_pkg::bus_word_t exp,
                                input logic got_last, input logic exp_last_bit);
        if (got !== exp) begin
            $display("[FAIL] t=%0t o_out_data beat: got %h, expected %h", $time, got, exp);
            stop_run();
        end else if (got_last !== exp_last_bit) begin
            $display("[FAIL] t=%0t o_out_last on beat: got %b, expected %b",
                     $time, got_last, exp_last_bit);
            stop_run();
        end
    endtask

    // Holds one input beat until a rising edge finds the DUT ready, sampled at the falling edge
    task automatic send_beat(input dm_split_pkg::bus_word_t d, input logic last);
        logic taken;
        taken = 1'b0;
        i_in_valid = 1'b1;
        i_in_data = d;
        i_in_last = last;
        while (!taken) begin
            @(negedge clk);
            taken = o_in_ready;
            @(posedge clk);
            #2;
        end
        i_in_valid = 1'b0;
    endtask

    // Write beat k carries the tag in its top byte and k below it
    task automatic send_request(input stim_t s);
        int beats;
        beats = (s.kind == dm_split_pkg::KIND_WRITE) ? int'(s.len) / 8 : 0;
        send_beat(make_header(s), beats == 0);
        for (int k = 0; k < beats; k++) begin
            send_beat({s.tag, 56'(k)}, k == beats - 1);
        end
    endtask

    // ============================================================
    // Processes
    // ============================================================

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Output stalls about one cycle in four
    initial begin
        i_out_ready = 1'b0;
        rng_state = 32'hb457_abc7;
        forever begin
            @(posedge clk);
            #2;
            rng_state = xorshift32(rng_state);
            i_out_ready = rng_state[0] | rng_state[1];
        end
    end

    // Every transfer is checked against the front of the expected queue
    initial begin
        dm_split_pkg::bus_word_t w;
        logic l;
        logic h;
        n_seen = 0;
        forever begin
            @(negedge clk);
            if (rst_n && o_out_valid && i_out_ready) begin
                if (exp_word.size() == 0) begin
                    $display("Output beat %h at %0t arrived after all expected beats",
                             o_out_data, $time);
                    stop_run();
                end else begin
                    w = exp_word.pop_front();
                    l = exp_last.pop_front();
                    h = exp_hdr.pop_front();
                    if (h) begin
                        compare_hdr(o_out_data, w, o_out_last, l);
                    end else begin
                        compare_beat(o_out_data, w, o_out_last, l);
                    end
                    n_seen++;
                end
            end
        end
    end

    initial begin
        wait (model_ready === 1'b1);
        repeat ((n_input + n_expected) * 40 + 500) @(posedge clk);
        $display("Timeout: only %0d of %0d output beats arrived in time", n_seen, n_expected);
        stop_run();
    end

    initial begin
        rst_n = 1'b0;
        i_in_valid = 1'b0;
        i_in_data = '0;
        i_in_last = 1'b0;
        n_input = 0;
        model_ready = 1'b0;
        load_table();
        build_expected();
        model_ready = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int r = 0; r < N_REQ; r++) begin
            send_request(stim[r]);
        end
        while (n_seen < n_expected) begin
            @(posedge clk);
        end
        // A few idle cycles let any extra output beat show up
        repeat (20) @(posedge clk);
        // A drained splitter holds no output beat and takes a new packet again
        @(negedge clk);
        if (o_out_valid !== 1'b0) begin
            $display("[FAIL] t=%0t o_out_valid when idle: got %b, expected %b",
                     $time, o_out_valid, 1'b0);
            stop_run();
        end else if (o_in_ready !== 1'b1) begin
            $display("[FAIL] t=%0t o_in_ready when idle: got %b, expected %b",
                     $time, o_in_ready, 1'b1);
            stop_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== all.f ====
hw/dm_split_pkg.sv
hw/hdr_data_separator.sv
hw/payload_fifo.sv
hw/req_chunker.sv
hw/chunk_merge.sv
hw/dm_req_splitter.sv
verif/dm_req_splitter_checker.sv
verif/dm_req_splitter_tb.sv

// ==== Makefile ====
TOP = dm_req_splitter_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^PASS: all tests$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log
